/* hdl/uncore_pkg.sv */
`default_nettype none

package uncore_pkg;

   // physical side of the memory port
   localparam int PA_WIDTH = 32;
   localparam int LG_L2_REQ_TAGS = 3;
   localparam int L2_CL_BITS = 128;
   localparam int OPCODE_WIDTH = 4;

   // one spare slot bit over the tag space
   localparam int LG_REQ_Q_DEPTH = LG_L2_REQ_TAGS + 1;

   // console byte buffer
   localparam int LG_PUTCHAR_DEPTH = 4;

   // room to count past a full queue
   localparam int INFLIGHT_WIDTH = LG_REQ_Q_DEPTH + 1;

   // one outbound request to memory
   typedef struct packed {
      logic [PA_WIDTH-1:0]       addr;
      logic [LG_L2_REQ_TAGS-1:0] tag;
      logic [L2_CL_BITS-1:0]     store_data;
      logic [OPCODE_WIDTH-1:0]   opcode;
   } mem_req_t;

   typedef logic [7:0] char_t;

   // GOT_L1D means the L1D side is finished and L1I is still pending,
   // GOT_L1I is the reverse
   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

endpackage : uncore_pkg

`default_nettype wire

/* hdl/req_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module req_queue
#(
   parameter type payload_t = logic [7:0],
   parameter int LG_DEPTH = 4
)
(
   input  logic     clk,
   input  logic     reset,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     pop
);

   payload_t entries [0:(1 << LG_DEPTH)-1];

   // extra msb tells a full ring from an empty one
   logic [LG_DEPTH:0] head_ptr;
   logic [LG_DEPTH:0] tail_ptr;
   logic              empty;
   logic              full;
   logic              push;
   logic              do_pop;

   assign empty = (head_ptr == tail_ptr);
   // same slot on a different lap
   assign full = (head_ptr[LG_DEPTH] != tail_ptr[LG_DEPTH]) &&
                 (head_ptr[LG_DEPTH-1:0] == tail_ptr[LG_DEPTH-1:0]);

   assign in_ready  = !full;
   assign out_valid = !empty;
   assign out_data  = entries[head_ptr[LG_DEPTH-1:0]];

   assign push   = in_valid && !full;
   assign do_pop = pop && !empty;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         head_ptr <= '0;
         tail_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            tail_ptr <= tail_ptr + (LG_DEPTH+1)'(1);
         end
         if (do_pop)
         begin
            head_ptr <= head_ptr + (LG_DEPTH+1)'(1);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         entries[tail_ptr[LG_DEPTH-1:0]] <= in_data;
      end
   end

   // consumer only pops what it can see
   assert property (@(posedge clk) disable iff (reset) pop |-> out_valid)
      else $error("req_queue: pop while empty");

   // head entry holds until it is taken
   assert property (@(posedge clk) disable iff (reset)
                    (out_valid && !pop) |=> $stable(out_data))
      else $error("req_queue: head changed without pop");

endmodule : req_queue

`default_nettype wire

/* hdl/mem_port.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_port
(
   input  logic                                 clk,
   input  logic                                 reset,

   // request side from the L2
   input  uncore_pkg::mem_req_t                 l2_req,
   input  logic                                 l2_req_valid,
   output logic                                 l2_req_ready,

   // external memory
   output uncore_pkg::mem_req_t                 mem_req,
   output logic                                 mem_req_valid,
   input  logic                                 mem_req_gnt,
   input  logic                                 mem_rsp_valid,

   output logic [uncore_pkg::INFLIGHT_WIDTH-1:0] inflight
);

   import uncore_pkg::*;

   logic req_accept;

   assign req_accept = l2_req_valid && l2_req_ready;

   // grant takes the head of the in-order queue toward memory
   req_queue
   #(
      .payload_t (mem_req_t),
      .LG_DEPTH  (LG_REQ_Q_DEPTH)
   )
   u_req_q
   (
      .clk       (clk),
      .reset     (reset),
      .in_data   (l2_req),
      .in_valid  (l2_req_valid),
      .in_ready  (l2_req_ready),
      .out_data  (mem_req),
      .out_valid (mem_req_valid),
      .pop       (mem_req_gnt)
   );

   // counts from acceptance, not from grant
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inflight <= '0;
      end
      else if (req_accept && !mem_rsp_valid)
      begin
         inflight <= inflight + INFLIGHT_WIDTH'(1);
      end
      else if (!req_accept && mem_rsp_valid)
      begin
         inflight <= inflight - INFLIGHT_WIDTH'(1);
      end
   end

   // memory never answers a request it was not given
   assert property (@(posedge clk) disable iff (reset)
                    mem_rsp_valid |-> (inflight != '0))
      else $error("mem_port: response with nothing outstanding");

endmodule : mem_port

`default_nettype wire

/* hdl/flush_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module flush_sequencer
(
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_complete,
   output logic l2_flush_req,
   output logic in_flush_mode
);

   import uncore_pkg::*;

   flush_state_t state;
   flush_state_t state_nxt;
   logic         mode_nxt;
   logic         l2_req_nxt;
   logic         l1d_done;
   logic         l1i_done;

   // done now or seen earlier
   assign l1d_done = l1d_flush_complete || (state == GOT_L1D);
   assign l1i_done = l1i_flush_complete || (state == GOT_L1I);

   always_comb
   begin
      state_nxt  = state;
      mode_nxt   = in_flush_mode;
      l2_req_nxt = 1'b0;

      case (state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1i && flush_req_l1d)
            begin
               state_nxt = WAIT_FOR_L1D_L1I;
               mode_nxt  = 1'b1;
            end
            // a cache not asked to flush counts as finished
            else if (flush_req_l1i)
            begin
               state_nxt = GOT_L1D;
               mode_nxt  = 1'b1;
            end
            else if (flush_req_l1d)
            begin
               state_nxt = GOT_L1I;
               mode_nxt  = 1'b1;
            end
         end
         WAIT_FOR_L1D_L1I, GOT_L1D, GOT_L1I:
         begin
            if (l1d_done && l1i_done)
            begin
               state_nxt  = FLUSH_L2;
               l2_req_nxt = 1'b1;
            end
            else if (l1d_done)
            begin
               state_nxt = GOT_L1D;
            end
            else if (l1i_done)
            begin
               state_nxt = GOT_L1I;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_complete)
            begin
               state_nxt = FLUSH_IDLE;
               mode_nxt  = 1'b0;
            end
         end
         default:
         begin
            state_nxt = FLUSH_IDLE;
            mode_nxt  = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= FLUSH_IDLE;
         in_flush_mode <= 1'b0;
         l2_flush_req  <= 1'b0;
      end
      else
      begin
         state         <= state_nxt;
         in_flush_mode <= mode_nxt;
         l2_flush_req  <= l2_req_nxt;
      end
   end

   // L2 is only ever asked from inside a flush
   assert property (@(posedge clk) disable iff (reset) l2_flush_req |-> in_flush_mode)
      else $error("flush_sequencer: L2 flush outside flush mode");

endmodule : flush_sequencer

`default_nettype wire

/* hdl/uncore_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uncore_top
(
   input  logic                                 clk,
   input  logic                                 reset,

   // requests from the L2 side
   input  uncore_pkg::mem_req_t                 l2_req,
   input  logic                                 l2_req_valid,
   output logic                                 l2_req_ready,

   // memory port
   output uncore_pkg::mem_req_t                 mem_req,
   output logic                                 mem_req_valid,
   input  logic                                 mem_req_gnt,
   input  logic                                 mem_rsp_valid,
   output logic [uncore_pkg::INFLIGHT_WIDTH-1:0] inflight,

   // flush handshake
   input  logic                                 flush_req_l1i,
   input  logic                                 flush_req_l1d,
   input  logic                                 l1i_flush_complete,
   input  logic                                 l1d_flush_complete,
   output logic                                 l2_flush_req,
   input  logic                                 l2_flush_complete,
   output logic                                 in_flush_mode,

   // console bytes
   input  uncore_pkg::char_t                    char_in,
   input  logic                                 char_valid,
   output logic                                 char_ready,
   output uncore_pkg::char_t                    putchar_fifo_out,
   output logic                                 putchar_fifo_empty,
   input  logic                                 putchar_fifo_pop
);

   import uncore_pkg::*;

   logic putchar_fifo_valid;

   assign putchar_fifo_empty = !putchar_fifo_valid;

   mem_port u_mem_port
   (
      .clk           (clk),
      .reset         (reset),
      .l2_req        (l2_req),
      .l2_req_valid  (l2_req_valid),
      .l2_req_ready  (l2_req_ready),
      .mem_req       (mem_req),
      .mem_req_valid (mem_req_valid),
      .mem_req_gnt   (mem_req_gnt),
      .mem_rsp_valid (mem_rsp_valid),
      .inflight      (inflight)
   );

   flush_sequencer u_flush_seq
   (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1i      (flush_req_l1i),
      .flush_req_l1d      (flush_req_l1d),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .l2_flush_req       (l2_flush_req),
      .in_flush_mode      (in_flush_mode)
   );

   req_queue
   #(
      .payload_t (char_t),
      .LG_DEPTH  (LG_PUTCHAR_DEPTH)
   )
   u_putchar_q
   (
      .clk       (clk),
      .reset     (reset),
      .in_data   (char_in),
      .in_valid  (char_valid),
      .in_ready  (char_ready),
      .out_data  (putchar_fifo_out),
      .out_valid (putchar_fifo_valid),
      .pop       (putchar_fifo_pop)
   );

endmodule : uncore_top

`default_nettype wire

/* test/tb_uncore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_uncore;

   import uncore_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DELAY  = 1;
   localparam int RESET_CYCLES = 8;
   localparam int ORDER_CYCLES = 300;
   localparam int DRAIN_CYCLES = 40;
   localparam int FULL_CYCLES  = 40;
   localparam int COUNT_CYCLES = 300;
   localparam int FLUSH_CYCLES = 30;
   localparam int CHAR_CYCLES  = 300;
   localparam int REQ_SLOTS    = 1 << LG_REQ_Q_DEPTH;
   localparam int CHAR_SLOTS   = 1 << LG_PUTCHAR_DEPTH;
   localparam int COUNT_LIMIT  = 24;
   // drains run after each of the three request tests
   localparam int TOTAL_CYCLES = RESET_CYCLES + ORDER_CYCLES + FULL_CYCLES + COUNT_CYCLES +
                                 3 * (DRAIN_CYCLES + 1) + 4 * FLUSH_CYCLES + CHAR_CYCLES;

   logic                      clk;
   logic                      reset;
   mem_req_t                  l2_req;
   logic                      l2_req_valid;
   logic                      l2_req_ready;
   mem_req_t                  mem_req;
   logic                      mem_req_valid;
   logic                      mem_req_gnt;
   logic                      mem_rsp_valid;
   logic [INFLIGHT_WIDTH-1:0] inflight;
   logic                      flush_req_l1i;
   logic                      flush_req_l1d;
   logic                      l1i_flush_complete;
   logic                      l1d_flush_complete;
   logic                      l2_flush_req;
   logic                      l2_flush_complete;
   logic                      in_flush_mode;
   char_t                     char_in;
   logic                      char_valid;
   logic                      char_ready;
   char_t                     putchar_fifo_out;
   logic                      putchar_fifo_empty;
   logic                      putchar_fifo_pop;

   // reference models
   mem_req_t    req_model [$];
   char_t       char_model [$];
   int          pend_count;
   int          accept_count;
   bit          req_taken;
   bit          char_taken;
   bit          fm_mode;
   bit          fm_l2_req;
   bit          fm_in_l2;
   bit          fm_wait_i;
   bit          fm_wait_d;

   string       cur_test;
   int          error_count;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   int unsigned seed_init;

   uncore_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #((TOTAL_CYCLES + 200) * CLK_PERIOD);
      $display("watchdog expired before all tests completed");
      $display("Something failed");
      $finish;
   end

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic record_failure(input string line);
      $display("%s", line);
      error_count++;
   endtask

   task automatic start_test(input string name);
      cur_test        = name;
      errors_at_start = error_count;
   endtask

   task automatic finish_test();
      tests_run++;
      if (error_count == errors_at_start)
         $display("test %s: passed", cur_test);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, error_count - errors_at_start);
      end
   endtask

   function automatic mem_req_t rand_req();
      mem_req_t r;
      r.addr       = $urandom;
      r.tag        = LG_L2_REQ_TAGS'($urandom);
      r.store_data = {$urandom, $urandom, $urandom, $urandom};
      r.opcode     = OPCODE_WIDTH'($urandom);
      return r;
   endfunction

   // checks one memory-side cycle, drives it, then advances the models
   task automatic req_cycle(input int valid_pct, input int gnt_pct, input int rsp_pct);
      bit take;
      next_cycle();
      if (mem_req_valid != (req_model.size() != 0))
         record_failure($sformatf("ERROR %s mem_req_valid: expected %0b actual %0b",
                                  cur_test, req_model.size() != 0, mem_req_valid));
      if (l2_req_ready != (req_model.size() < REQ_SLOTS))
         record_failure($sformatf("ERROR %s l2_req_ready: expected %0b actual %0b",
                                  cur_test, req_model.size() < REQ_SLOTS, l2_req_ready));
      if (int'(inflight) != pend_count)
         record_failure($sformatf("ERROR %s inflight: expected %0d actual %0d",
                                  cur_test, pend_count, inflight));
      // a request still waiting keeps its valid and data
      if (!l2_req_valid || req_taken)
      begin
         l2_req_valid = (pend_count < COUNT_LIMIT) && ($urandom_range(0, 99) < valid_pct);
         l2_req       = rand_req();
      end
      mem_req_gnt   = mem_req_valid && ($urandom_range(0, 99) < gnt_pct);
      mem_rsp_valid = (pend_count > 0) && ($urandom_range(0, 99) < rsp_pct);
      if (mem_req_gnt && req_model.size() != 0)
      begin
         if (mem_req != req_model[0])
            record_failure($sformatf("ERROR %s mem_req: expected %h actual %h",
                                     cur_test, req_model[0], mem_req));
         void'(req_model.pop_front());
      end
      take = l2_req_valid && l2_req_ready;
      if (take)
      begin
         req_model.push_back(l2_req);
         accept_count++;
      end
      req_taken  = take;
      pend_count = pend_count + int'(take) - int'(mem_rsp_valid);
   endtask

   task automatic drain_requests();
      int guard;
      guard = 0;
      while ((req_model.size() != 0 || l2_req_valid || pend_count != 0) &&
             guard < DRAIN_CYCLES)
      begin
         req_cycle(0, 100, 100);
         guard++;
      end
      if (guard == DRAIN_CYCLES)
         record_failure($sformatf("%s: memory side did not drain in %0d cycles",
                                  cur_test, DRAIN_CYCLES));
      next_cycle();
      l2_req_valid  = 1'b0;
      mem_req_gnt   = 1'b0;
      mem_rsp_valid = 1'b0;
   endtask

   task automatic flush_model_step(input bit ri, input bit rd, input bit ci, input bit cd,
                                   input bit c2);
      bit l2_next;
      l2_next = 1'b0;
      if (!fm_mode)
      begin
         if (ri || rd)
         begin
            fm_mode   = 1'b1;
            fm_in_l2  = 1'b0;
            // a cache not asked has nothing to wait for
            fm_wait_i = ri;
            fm_wait_d = rd;
         end
      end
      else if (!fm_in_l2)
      begin
         if (ci)
            fm_wait_i = 1'b0;
         if (cd)
            fm_wait_d = 1'b0;
         if (!fm_wait_i && !fm_wait_d)
         begin
            fm_in_l2 = 1'b1;
            l2_next  = 1'b1;
         end
      end
      else if (c2)
         fm_mode = 1'b0;
      fm_l2_req = l2_next;
   endtask

   task automatic flush_run(input bit ask_i, input bit ask_d, input bit extras);
      int t_i;
      int t_d;
      int t_last;
      int t_l2;
      int cyc;
      int l2_pulses;
      t_i    = 2 + int'($urandom_range(0, 5));
      t_d    = 2 + int'($urandom_range(0, 5));
      t_last = ask_i ? t_i : 0;
      if (ask_d && t_d > t_last)
         t_last = t_d;
      t_l2      = t_last + 3 + int'($urandom_range(0, 4));
      l2_pulses = 0;
      for (cyc = 0; cyc < FLUSH_CYCLES; cyc++)
      begin
         next_cycle();
         if (in_flush_mode != fm_mode)
            record_failure($sformatf("ERROR %s in_flush_mode: expected %0b actual %0b",
                                     cur_test, fm_mode, in_flush_mode));
         if (l2_flush_req != fm_l2_req)
            record_failure($sformatf("ERROR %s l2_flush_req: expected %0b actual %0b",
                                     cur_test, fm_l2_req, l2_flush_req));
         if (l2_flush_req)
            l2_pulses++;
         // stray requests while busy must be ignored
         flush_req_l1i = (cyc == 0) ? ask_i :
                         (extras && cyc <= t_l2 && $urandom_range(0, 3) == 0);
         flush_req_l1d = (cyc == 0) ? ask_d :
                         (extras && cyc <= t_l2 && $urandom_range(0, 3) == 0);
         l1i_flush_complete = ask_i && (cyc == t_i);
         l1d_flush_complete = ask_d && (cyc == t_d);
         l2_flush_complete  = (cyc == t_l2);
         flush_model_step(flush_req_l1i, flush_req_l1d, l1i_flush_complete,
                          l1d_flush_complete, l2_flush_complete);
      end
      if (l2_pulses != 1)
         record_failure($sformatf("ERROR %s l2_flush_req pulses: expected 1 actual %0d",
                                  cur_test, l2_pulses));
   endtask

   task automatic char_cycle(input int push_pct, input int pop_pct);
      bit take;
      next_cycle();
      if (putchar_fifo_empty != (char_model.size() == 0))
         record_failure($sformatf("ERROR %s putchar_fifo_empty: expected %0b actual %0b",
                                  cur_test, char_model.size() == 0, putchar_fifo_empty));
      if (char_ready != (char_model.size() < CHAR_SLOTS))
         record_failure($sformatf("ERROR %s char_ready: expected %0b actual %0b",
                                  cur_test, char_model.size() < CHAR_SLOTS, char_ready));
      if (char_model.size() != 0 && putchar_fifo_out != char_model[0])
         record_failure($sformatf("ERROR %s putchar_fifo_out: expected %h actual %h",
                                  cur_test, char_model[0], putchar_fifo_out));
      if (!char_valid || char_taken)
      begin
         char_valid = ($urandom_range(0, 99) < push_pct);
         char_in    = 8'($urandom);
      end
      putchar_fifo_pop = (char_model.size() != 0) && ($urandom_range(0, 99) < pop_pct);
      if (putchar_fifo_pop)
         void'(char_model.pop_front());
      take = char_valid && char_ready;
      if (take)
         char_model.push_back(char_in);
      char_taken = take;
   endtask

   initial
   begin
      seed_init          = $urandom(20);
      reset              = 1'b1;
      l2_req             = '0;
      l2_req_valid       = 1'b0;
      mem_req_gnt        = 1'b0;
      mem_rsp_valid      = 1'b0;
      flush_req_l1i      = 1'b0;
      flush_req_l1d      = 1'b0;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      l2_flush_complete  = 1'b0;
      char_in            = '0;
      char_valid         = 1'b0;
      putchar_fifo_pop   = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      start_test("request_order");
      repeat (ORDER_CYCLES) req_cycle(60, 50, 30);
      drain_requests();
      finish_test();

      start_test("back_pressure");
      accept_count = 0;
      repeat (20) req_cycle(100, 0, 0);
      if (accept_count != REQ_SLOTS)
         record_failure($sformatf("ERROR %s accepts before full: expected %0d actual %0d",
                                  cur_test, REQ_SLOTS, accept_count));
      if (l2_req_ready)
         record_failure($sformatf("ERROR %s l2_req_ready when full: expected 0 actual %0b",
                                  cur_test, l2_req_ready));
      // one grant frees a slot for the waiting request
      req_cycle(100, 100, 0);
      drain_requests();
      if (accept_count != REQ_SLOTS + 1)
         record_failure($sformatf("ERROR %s total accepts: expected %0d actual %0d",
                                  cur_test, REQ_SLOTS + 1, accept_count));
      finish_test();

      start_test("inflight_count");
      repeat (COUNT_CYCLES) req_cycle(80, 60, 35);
      drain_requests();
      finish_test();

      start_test("flush_both");
      flush_run(1'b1, 1'b1, 1'b1);
      flush_run(1'b1, 1'b1, 1'b1);
      finish_test();

      start_test("flush_single");
      flush_run(1'b1, 1'b0, 1'b0);
      flush_run(1'b0, 1'b1, 1'b0);
      finish_test();

      start_test("putchar_fifo");
      repeat (CHAR_CYCLES) char_cycle(55, 45);
      finish_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule : tb_uncore

`default_nettype wire

/* compile.f */
hdl/uncore_pkg.sv
hdl/req_queue.sv
hdl/mem_port.sv
hdl/flush_sequencer.sv
hdl/uncore_top.sv
test/tb_uncore.sv

/* run.sh */
#!/bin/bash
# build and run the uncore testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_uncore \
   --Mdir obj_dir -o sim_uncore > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_uncore > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
